//--- Bender.yml
package:
  name: flag_table

sources:
  # RTL, package first
  - hdl/flag_table_pkg.sv
  - hdl/flag_ram.sv
  - hdl/flag_apb_decode.sv
  - hdl/flag_rmw_execute.sv
  - hdl/flag_rmw_result.sv
  - hdl/flag_table_top.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - bench/flag_table_checker.sv
      - bench/flag_table_tb.sv

//--- bench/flag_table_checker.sv
/*
 * Handshake and latency assertions for flag_table_top, attached with bind.
 * All properties are disabled while rst is high.
 */
`timescale 1ns/10ps

module flag_table_checker (
    input logic clk,
    input logic rst,
    input logic init_done,
    input logic upd_valid,
    input logic upd_rdy,
    input logic upd_ack_valid,
    input logic psel,
    input logic penable,
    input logic pready
);

    // Running count of failed properties
    int fails = 0;

    // Accepted update is acknowledged exactly 3 cycles later
    assert property (@(posedge clk) disable iff (rst)
        (upd_valid && upd_rdy) |-> ##3 upd_ack_valid)
        else begin
            fails++;
            $error("upd_ack_valid missing 3 cycles after an accepted update");
        end

    // No acknowledgement without an update 3 cycles earlier
    assert property (@(posedge clk) disable iff (rst)
        upd_ack_valid |-> $past(upd_valid && upd_rdy, 3))
        else begin
            fails++;
            $error("upd_ack_valid without an update accepted 3 cycles before");
        end

    // Update port stays closed during the clear sweep
    assert property (@(posedge clk) disable iff (rst) !init_done |-> !upd_rdy)
        else begin
            fails++;
            $error("upd_rdy high before init_done");
        end

    // pready only in an APB access phase
    assert property (@(posedge clk) disable iff (rst) pready |-> (psel && penable))
        else begin
            fails++;
            $error("pready high outside an access phase");
        end

endmodule

bind flag_table_top flag_table_checker checker0 (
    .clk(clk), .rst(rst), .init_done(init_done),
    .upd_valid(upd_valid), .upd_rdy(upd_rdy), .upd_ack_valid(upd_ack_valid),
    .psel(psel), .penable(penable), .pready(pready)
);

//--- bench/flag_table_tb.sv
/*
 * Self-checking testbench for flag_table_top.
 * Update and APB stimulus come from two LFSR streams, both started from seed 77512.
 * The reference array is updated in completion order, which is acceptance order.
 * The run is bounded by a cycle limit worked out from the number of operations.
 */
`timescale 1ns/10ps

module flag_table_tb;
    import flag_table_pkg::*;

    localparam int N_UPD   = 2000;
    localparam int N_APB   = 200;
    localparam int TIMEOUT = 64 + N_UPD * 2 + N_APB * 40;

    // Accepted update waiting for its acknowledgement
    typedef struct packed {
        upd_req_t    req;
        logic [31:0] stamp;
    } pend_t;

    logic        clk;
    logic        rst;
    logic        init_done;
    logic        upd_valid;
    upd_req_t    upd_req;
    logic        upd_rdy;
    logic        upd_ack_valid;
    upd_ack_t    upd_ack;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    logic [31:0] pwdata;
    logic        pready;
    logic [31:0] prdata;
    logic        pslverr;

    flags_t      model [DEPTH];
    pend_t       pending [$];
    logic [31:0] cycle;
    logic [31:0] upd_lfsr;
    logic [31:0] apb_lfsr;
    int          value_errs;
    int          other_errs;
    string       test_name;

    flag_table_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ----------------------------------------
    // Random numbers
    // ----------------------------------------

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // One step per bit taken
    task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_step(state);
            bits  = {bits[30:0], state[0]};
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic drive_update(input upd_req_t req);
        @(posedge clk);
        upd_valid <= 1'b1;
        upd_req   <= req;
    endtask

    task automatic update_stream(input int n);
        logic [31:0] r;
        upd_req_t    req;
        for (int i = 0; i < n; i++) begin
            // About 60% valid
            take_bits(upd_lfsr, 7, r);
            if (r < 77) begin
                // First half hits only 8 IDs
                if (i < n / 2) begin
                    take_bits(upd_lfsr, 3, r);
                    req.id = {r[2:0], 3'b010};
                end else begin
                    take_bits(upd_lfsr, 6, r);
                    req.id = r[5:0];
                end
                take_bits(upd_lfsr, 8, r);
                req.init = (r < 51);
                take_bits(upd_lfsr, 16, r);
                // Sparse OR masks so entries do not saturate
                req.flags = req.init ? r[7:0] : (r[7:0] & r[15:8]);
                drive_update(req);
            end else begin
                @(posedge clk);
                upd_valid <= 1'b0;
            end
        end
        @(posedge clk);
        upd_valid <= 1'b0;
    endtask

    // Setup and access phase held until pready
    task automatic apb_access(input apb_addr_t addr, input logic wr, input flags_t data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= {24'h0, data};
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        while (!pready) @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // Write then read of one address with about 5% bad addresses
    task automatic random_apb_pairs(input int n);
        logic [31:0] r;
        apb_addr_t   addr;
        flags_t      data;
        for (int i = 0; i < n; i += 2) begin
            take_bits(apb_lfsr, 1, r);
            if (r[0]) begin
                take_bits(apb_lfsr, 3, r);
                addr = {2'b00, r[2:0], 3'b010, 2'b00};
            end else begin
                take_bits(apb_lfsr, 6, r);
                addr = {2'b00, r[5:0], 2'b00};
            end
            take_bits(apb_lfsr, 8, r);
            if (r < 13) begin
                take_bits(apb_lfsr, 1, r);
                if (r[0]) begin
                    take_bits(apb_lfsr, 9, r);
                    addr = 10'd256 + apb_addr_t'(r[8:0]);
                end else begin
                    take_bits(apb_lfsr, 2, r);
                    addr[1:0] = (r[1:0] == 2'b00) ? 2'b11 : r[1:0];
                end
            end
            take_bits(apb_lfsr, 8, r);
            data = r[7:0];
            apb_access(addr, 1'b1, data);
            apb_access(addr, 1'b0, 8'h00);
            take_bits(apb_lfsr, 2, r);
            repeat (r[1:0]) @(posedge clk);
        end
    endtask

    // ----------------------------------------
    // Monitor, reference model and timeout
    // ----------------------------------------
    always @(posedge clk) begin : monitor
        pend_t p;
        logic  bad;
        if (upd_valid && upd_rdy) begin
            p.req   = upd_req;
            p.stamp = cycle;
            pending.push_back(p);
        end
        if (upd_ack_valid) begin
            if (pending.size() == 0) begin
                $display("%s: update acknowledgement with no update pending", test_name);
                other_errs++;
            end else begin
                p = pending.pop_front();
                if (upd_ack.id != p.req.id) begin
                    $display("CHECK FAILED %s: ack id expected %h actual %h",
                             test_name, p.req.id, upd_ack.id);
                    value_errs++;
                end
                if (upd_ack.flags != model[p.req.id]) begin
                    $display("CHECK FAILED %s: old flags of id %h expected %h actual %h",
                             test_name, p.req.id, model[p.req.id], upd_ack.flags);
                    value_errs++;
                end
                if (cycle - p.stamp != 3) begin
                    $display("CHECK FAILED %s: ack latency expected %0d actual %0d",
                             test_name, 3, cycle - p.stamp);
                    value_errs++;
                end
                // Replace or OR
                model[p.req.id] = p.req.init ? p.req.flags : (model[p.req.id] | p.req.flags);
            end
        end
        if (psel && penable && pready) begin
            bad = (paddr[1:0] != 2'b00) || (paddr >= 10'd256);
            if (pslverr != bad) begin
                $display("CHECK FAILED %s: pslverr at paddr %h expected %b actual %b",
                         test_name, paddr, bad, pslverr);
                value_errs++;
            end else if (!bad && pwrite) begin
                model[paddr[ID_WID+1:2]] = pwdata[FLAG_WID-1:0];
            end else if (!bad && (prdata != {24'h0, model[paddr[ID_WID+1:2]]})) begin
                $display("CHECK FAILED %s: prdata at paddr %h expected %h actual %h",
                         test_name, paddr, {24'h0, model[paddr[ID_WID+1:2]]}, prdata);
                value_errs++;
            end
        end
        cycle = cycle + 1;
        if (cycle >= TIMEOUT) begin
            $display("Timeout after %0d cycles, stimulus did not complete", cycle);
            $display("Test failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin : main
        int          wait_cycles;
        int          assert_errs;
        logic [31:0] r;
        rst        = 1'b1;
        upd_valid  = 1'b0;
        upd_req    = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        cycle      = '0;
        value_errs = 0;
        other_errs = 0;
        test_name  = "init_time";
        for (int i = 0; i < DEPTH; i++) begin
            model[i] = '0;
        end
        upd_lfsr = 32'd77512;
        apb_lfsr = 32'd77512;
        // APB stream runs 1000 bits ahead of the update stream
        for (int i = 0; i < 1000; i++) begin
            apb_lfsr = lfsr_step(apb_lfsr);
        end

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        wait_cycles = 0;
        do begin
            @(posedge clk);
            wait_cycles++;
        end while (!init_done);
        if (wait_cycles != DEPTH + 1) begin
            $display("CHECK FAILED %s: cycles to init_done expected %0d actual %0d",
                     test_name, DEPTH + 1, wait_cycles);
            value_errs++;
        end

        // Cleared entries read back as zero
        test_name = "init_zero";
        for (int i = 0; i < 16; i++) begin
            take_bits(apb_lfsr, 6, r);
            apb_access({2'b00, r[5:0], 2'b00}, 1'b0, 8'h00);
        end

        // Back-to-back updates to one ID with a replace inside the second burst
        test_name = "fwd_burst";
        drive_update({6'd5, 1'b1, 8'h01});
        for (int k = 1; k < 8; k++) begin
            drive_update({6'd5, 1'b0, flags_t'(1 << k)});
        end
        drive_update({6'd9, 1'b0, 8'h0f});
        drive_update({6'd9, 1'b1, 8'h30});
        drive_update({6'd9, 1'b0, 8'h03});
        @(posedge clk);
        upd_valid <= 1'b0;
        repeat (4) @(posedge clk);

        // Control write and read with updates to the same ID in between
        test_name = "apb_wr_rd";
        fork
            begin
                apb_access(10'd48, 1'b1, 8'ha5);
                apb_access(10'd48, 1'b0, 8'h00);
            end
            repeat (6) begin
                drive_update({6'd12, 1'b0, 8'h40});
                @(posedge clk);
                upd_valid <= 1'b0;
            end
        join

        test_name = "random";
        fork
            update_stream(N_UPD);
            random_apb_pairs(N_APB);
        join

        // Bad accesses and then a read of every entry
        test_name = "final_sweep";
        apb_access(10'h3fc, 1'b1, 8'hff);
        apb_access(10'd49, 1'b1, 8'hff);
        for (int i = 0; i < DEPTH; i++) begin
            apb_access({2'b00, flag_id_t'(i), 2'b00}, 1'b0, 8'h00);
        end
        while (pending.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);

        // Failed bound properties count against the run as well
        assert_errs = dut0.checker0.fails;
        $display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 value_errs, other_errs, assert_errs);
        if (value_errs + other_errs + assert_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
hdl/flag_table_pkg.sv
hdl/flag_ram.sv
hdl/flag_apb_decode.sv
hdl/flag_rmw_execute.sv
hdl/flag_rmw_result.sv
hdl/flag_table_top.sv
bench/flag_table_checker.sv
bench/flag_table_tb.sv

//--- hdl/flag_apb_decode.sv
/*
 * APB slave front end of the flag table.
 * Entry n is at byte 4n. Misaligned or out-of-range accesses finish with pslverr
 * in their first access cycle and issue no command.
 * One command is outstanding at a time; the access phase lasts until ctrl_done.
 * Write data is taken from the low FLAG_WID bits of pwdata.
 */
`timescale 1ns/10ps

module flag_apb_decode (
    input  logic                       clk,
    input  logic                       rst,
    // APB slave
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  flag_table_pkg::apb_addr_t  paddr,
    input  logic [31:0]                pwdata,
    output logic                       pready,
    output logic [31:0]                prdata,
    output logic                       pslverr,
    // Command to execute
    output logic                       ctrl_valid,
    output flag_table_pkg::ctrl_cmd_t  ctrl_cmd,
    input  logic                       ctrl_grant,
    // Completion from result
    input  logic                       ctrl_done,
    input  flag_table_pkg::flags_t     ctrl_rdata
);
    import flag_table_pkg::*;

    logic addr_err;
    logic setup;
    logic busy;

    // ----------------------------------------
    // Address check
    // ----------------------------------------

    // Word aligned, and no bits set above the entry index
    assign addr_err = (paddr[1:0] != 2'b00) ||
                      (paddr[ADDR_WID-1:ID_WID+2] != '0);

    // Every APB transfer has exactly one setup cycle
    assign setup = psel && !penable;

    // ----------------------------------------
    // Command handshake
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_valid <= 1'b0;
            busy       <= 1'b0;
        end else if (setup && !addr_err) begin
            ctrl_valid <= 1'b1;
            busy       <= 1'b1;
        end else begin
            // Held until execute takes it
            if (ctrl_grant) begin
                ctrl_valid <= 1'b0;
            end
            if (ctrl_done) begin
                busy <= 1'b0;
            end
        end
    end

    // Command payload, captured at setup
    always_ff @(posedge clk) begin
        if (setup && !addr_err) begin
            ctrl_cmd.id    <= paddr[ID_WID+1:2];
            ctrl_cmd.wr    <= pwrite;
            ctrl_cmd.flags <= pwdata[FLAG_WID-1:0];
        end
    end

    // ----------------------------------------
    // APB response
    // ----------------------------------------

    // Error completes at once, good access waits for its result
    assign pready  = psel && penable && (addr_err || (busy && ctrl_done));
    assign pslverr = psel && penable && addr_err;

    // Zero-extended read data
    assign prdata  = {{(32-FLAG_WID){1'b0}}, ctrl_rdata};

endmodule

//--- hdl/flag_ram.sv
/*
 * Simple dual-port flag RAM with a two-cycle registered read.
 * After reset every entry is cleared to zero, one per cycle, then init_done rises.
 * Reads and writes issued before init_done are ignored.
 * A read in the same cycle as a write to the same entry returns the old value.
 */
`timescale 1ns/10ps

module flag_ram (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rd_en,
    input  flag_table_pkg::flag_id_t rd_addr,
    output flag_table_pkg::flags_t   rd_data,
    input  logic                     wr_en,
    input  flag_table_pkg::flag_id_t wr_addr,
    input  flag_table_pkg::flags_t   wr_data,
    output logic                     init_done
);
    import flag_table_pkg::*;

    flags_t          mem [DEPTH];
    flags_t          rd_q;
    ram_init_state_t state;
    flag_id_t        clr_addr;

    // ----------------------------------------
    // Clear sweep
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= INIT_CLEAR;
            clr_addr <= '0;
        end else if (state == INIT_CLEAR) begin
            clr_addr <= clr_addr + 1'b1;
            // Last entry cleared in this cycle
            if (clr_addr == flag_id_t'(DEPTH - 1)) begin
                state <= INIT_DONE;
            end
        end
    end

    assign init_done = (state == INIT_DONE);

    // Sweep owns the write port until done
    always_ff @(posedge clk) begin
        if (state == INIT_CLEAR) begin
            mem[clr_addr] <= '0;
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // ----------------------------------------
    // Two-stage read
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rd_en && init_done) begin
            rd_q <= mem[rd_addr];
        end
        // Output stage
        rd_data <= rd_q;
    end

endmodule

//--- hdl/flag_rmw_execute.sv
/*
 * Arbitration, operation context pipeline and same-ID forwarding.
 * Updates have strict priority; a long update burst starves control commands.
 * Nothing is accepted before init_done. After that updates are never stalled.
 * The RAM read is issued in the acceptance cycle, and op_out and fwd_flags are
 * valid RD_LATENCY cycles later. fwd_flags already includes every earlier
 * operation that had not reached the RAM when the read was issued.
 */
`timescale 1ns/10ps

module flag_rmw_execute (
    input  logic                      clk,
    input  logic                      rst,
    // Update port
    input  logic                      upd_valid,
    input  flag_table_pkg::upd_req_t  upd_req,
    output logic                      upd_rdy,
    // Control command
    input  logic                      ctrl_valid,
    input  flag_table_pkg::ctrl_cmd_t ctrl_cmd,
    output logic                      ctrl_grant,
    // RAM read port
    input  logic                      init_done,
    output logic                      rd_en,
    output flag_table_pkg::flag_id_t  rd_addr,
    input  flag_table_pkg::flags_t    rd_data,
    // To result
    output flag_table_pkg::rmw_op_t   op_out,
    output flag_table_pkg::flags_t    fwd_flags
);
    import flag_table_pkg::*;

    // Correction to apply to a stale RAM read
    typedef struct packed {
        logic   init;
        flags_t flags;
    } fwd_adj_t;

    logic     upd_take;
    logic     ctrl_take;
    rmw_op_t  op_in;
    rmw_op_t  op_wr;
    rmw_op_t  ctx     [1:RD_LATENCY];
    fwd_adj_t adj     [1:RD_LATENCY];
    fwd_adj_t adj_nxt [1:RD_LATENCY];

    // ----------------------------------------
    // Arbitration
    // ----------------------------------------
    assign upd_rdy    = init_done;
    assign upd_take   = upd_valid && init_done;
    // Control only in cycles with no update offered
    assign ctrl_take  = ctrl_valid && init_done && !upd_valid;
    assign ctrl_grant = ctrl_take;

    always_comb begin
        op_in = '0;
        if (upd_take) begin
            op_in.valid  = 1'b1;
            op_in.ctrl   = 1'b0;
            op_in.id     = upd_req.id;
            op_in.init   = upd_req.init;
            op_in.update = 1'b1;
            op_in.flags  = upd_req.flags;
        end else if (ctrl_take) begin
            // Control write replaces the entry, control read leaves it alone
            op_in.valid  = 1'b1;
            op_in.ctrl   = 1'b1;
            op_in.id     = ctrl_cmd.id;
            op_in.init   = ctrl_cmd.wr;
            op_in.update = ctrl_cmd.wr;
            op_in.flags  = ctrl_cmd.wr ? ctrl_cmd.flags : '0;
        end
    end

    // Read issued in the acceptance cycle
    assign rd_en   = op_in.valid;
    assign rd_addr = op_in.id;

    // ----------------------------------------
    // Context pipeline
    // ----------------------------------------
    always_ff @(posedge clk) begin
        ctx[1] <= op_in;
        for (int i = 2; i <= RD_LATENCY; i++) begin
            ctx[i] <= ctx[i-1];
        end
        if (rst) begin
            for (int i = 1; i <= RD_LATENCY; i++) begin
                ctx[i].valid <= 1'b0;
            end
        end
    end

    // Last stage is the op whose write happens this cycle
    assign op_wr  = ctx[RD_LATENCY];
    assign op_out = op_wr;

    // ----------------------------------------
    // Forwarding
    // ----------------------------------------

    // Every younger op is checked against the op being written.
    // A write lands one cycle too late for the reads of the next
    // RD_LATENCY ops, so those pick it up here instead
    always_comb begin
        fwd_adj_t src;
        flag_id_t src_id;
        for (int i = 1; i <= RD_LATENCY; i++) begin
            if (i == 1) begin
                // Op entering the pipe starts clean
                src    = '0;
                src_id = op_in.id;
            end else begin
                src    = adj[i-1];
                src_id = ctx[i-1].id;
            end
            adj_nxt[i] = src;
            if (op_wr.valid && op_wr.update && (op_wr.id == src_id)) begin
                if (op_wr.init) begin
                    // Replace wipes anything older
                    adj_nxt[i].init  = 1'b1;
                    adj_nxt[i].flags = op_wr.flags;
                end else begin
                    adj_nxt[i].flags = src.flags | op_wr.flags;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 1; i <= RD_LATENCY; i++) begin
            adj[i] <= adj_nxt[i];
        end
    end

    // Corrected old flags, aligned with op_out
    assign fwd_flags = adj[RD_LATENCY].init ? adj[RD_LATENCY].flags :
                                              (rd_data | adj[RD_LATENCY].flags);

endmodule

//--- hdl/flag_rmw_result.sv
/*
 * Write-back stage of the read-modify-write pipeline.
 * The merged value is written to the RAM in the cycle op_out is valid.
 * Acknowledgements are registered one cycle later and carry the old flags.
 * The acknowledgement outputs have no back-pressure.
 */
`timescale 1ns/10ps

module flag_rmw_result (
    input  logic                     clk,
    input  logic                     rst,
    // From execute
    input  flag_table_pkg::rmw_op_t  op_out,
    input  flag_table_pkg::flags_t   fwd_flags,
    // RAM write port
    output logic                     wr_en,
    output flag_table_pkg::flag_id_t wr_addr,
    output flag_table_pkg::flags_t   wr_data,
    // Update acknowledgement
    output logic                     upd_ack_valid,
    output flag_table_pkg::upd_ack_t upd_ack,
    // Control completion
    output logic                     ctrl_done,
    output flag_table_pkg::flags_t   ctrl_rdata
);
    import flag_table_pkg::*;

    flags_t new_flags;

    // ----------------------------------------
    // Merge and write
    // ----------------------------------------
    assign new_flags = op_out.init ? op_out.flags : (fwd_flags | op_out.flags);

    assign wr_en   = op_out.valid && op_out.update;
    assign wr_addr = op_out.id;
    assign wr_data = new_flags;

    // ----------------------------------------
    // Acknowledgements
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            upd_ack_valid <= 1'b0;
            ctrl_done     <= 1'b0;
        end else begin
            upd_ack_valid <= op_out.valid && !op_out.ctrl;
            ctrl_done     <= op_out.valid && op_out.ctrl;
        end
    end

    // Old flags go back on both ports
    always_ff @(posedge clk) begin
        upd_ack.id    <= op_out.id;
        upd_ack.flags <= fwd_flags;
        ctrl_rdata    <= fwd_flags;
    end

endmodule

//--- hdl/flag_table_pkg.sv
/*
 * Shared widths, latencies and types for the per-ID flag table.
 * The table holds DEPTH entries of FLAG_WID bits, indexed by an ID_WID-bit ID.
 * RD_LATENCY must match the registered read depth of flag_ram.
 * APB entry n sits at byte address 4n, and only the low 256 bytes are decoded.
 */
package flag_table_pkg;

    // ----------------------------------------
    // Widths and latencies
    // ----------------------------------------
    localparam int ID_WID     = 6;
    localparam int FLAG_WID   = 8;
    localparam int DEPTH      = 2**ID_WID;
    localparam int RD_LATENCY = 2;
    localparam int ADDR_WID   = 10;

    // ----------------------------------------
    // Vector types
    // ----------------------------------------
    typedef logic [ID_WID-1:0]   flag_id_t;
    typedef logic [FLAG_WID-1:0] flags_t;
    typedef logic [ADDR_WID-1:0] apb_addr_t;

    // ----------------------------------------
    // Handshake payloads
    // ----------------------------------------

    // Update request from the data plane
    typedef struct packed {
        flag_id_t id;
        logic     init;   // Replace instead of OR
        flags_t   flags;
    } upd_req_t;

    // Update acknowledgement, flags as they were before the update
    typedef struct packed {
        flag_id_t id;
        flags_t   flags;
    } upd_ack_t;

    // Control command from the APB decoder
    typedef struct packed {
        flag_id_t id;
        logic     wr;
        flags_t   flags;
    } ctrl_cmd_t;

    // One read-modify-write operation in flight
    typedef struct packed {
        logic     valid;
        logic     ctrl;     // Came from the control plane
        flag_id_t id;
        logic     init;     // Replace the entry
        logic     update;   // Entry is written back
        flags_t   flags;
    } rmw_op_t;

    // RAM clear sweep after reset
    typedef enum logic {
        INIT_CLEAR,
        INIT_DONE
    } ram_init_state_t;

endpackage

//--- hdl/flag_table_top.sv
/*
 * Per-ID flag table, DEPTH entries of FLAG_WID bits.
 * Update port has priority over APB and is ready once init_done is high.
 * Acknowledgements come 3 cycles after acceptance, in acceptance order.
 */
`timescale 1ns/10ps

module flag_table_top (
    input  logic                      clk,
    input  logic                      rst,
    output logic                      init_done,
    // Update port
    input  logic                      upd_valid,
    input  flag_table_pkg::upd_req_t  upd_req,
    output logic                      upd_rdy,
    output logic                      upd_ack_valid,
    output flag_table_pkg::upd_ack_t  upd_ack,
    // APB slave
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  flag_table_pkg::apb_addr_t paddr,
    input  logic [31:0]               pwdata,
    output logic                      pready,
    output logic [31:0]               prdata,
    output logic                      pslverr
);
    import flag_table_pkg::*;

    // Decode to execute
    logic      ctrl_valid;
    logic      ctrl_grant;
    ctrl_cmd_t ctrl_cmd;

    // Result to decode
    logic      ctrl_done;
    flags_t    ctrl_rdata;

    // RAM ports
    logic      rd_en;
    flag_id_t  rd_addr;
    flags_t    rd_data;
    logic      wr_en;
    flag_id_t  wr_addr;
    flags_t    wr_data;

    // Execute to result
    rmw_op_t   op_out;
    flags_t    fwd_flags;

    flag_ram ram0 (
        .clk(clk), .rst(rst),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .init_done(init_done)
    );

    flag_apb_decode decode0 (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .pready(pready), .prdata(prdata), .pslverr(pslverr),
        .ctrl_valid(ctrl_valid), .ctrl_cmd(ctrl_cmd), .ctrl_grant(ctrl_grant),
        .ctrl_done(ctrl_done), .ctrl_rdata(ctrl_rdata)
    );

    flag_rmw_execute execute0 (
        .clk(clk), .rst(rst),
        .upd_valid(upd_valid), .upd_req(upd_req), .upd_rdy(upd_rdy),
        .ctrl_valid(ctrl_valid), .ctrl_cmd(ctrl_cmd), .ctrl_grant(ctrl_grant),
        .init_done(init_done), .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
        .op_out(op_out), .fwd_flags(fwd_flags)
    );

    flag_rmw_result result0 (
        .clk(clk), .rst(rst),
        .op_out(op_out), .fwd_flags(fwd_flags),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .upd_ack_valid(upd_ack_valid), .upd_ack(upd_ack),
        .ctrl_done(ctrl_done), .ctrl_rdata(ctrl_rdata)
    );

endmodule
